//--- files.f
hdl/wav_pkg.sv
hdl/gamepad_decoder.sv
hdl/card_sequencer.sv
hdl/wav_header_parser.sv
hdl/file_list_ram.sv
hdl/sample_fifo.sv
hdl/wav_player.sv
verification/card_host_model.sv
verification/wav_player_tb.sv

//--- hdl/card_sequencer.sv
`default_nettype none

module card_sequencer #(
	parameter int LIST_AW = 13
) (
	input wire clockFiler,
	input wire rst_n,
	input wire wav_pkg::host_op_e host_op,
	input wire [wav_pkg::HOST_ID_W-1:0] host_id,
	input wire [31:0] host_data,
	input wire [wav_pkg::SEL_W-1:0] sel,
	input wire play_req,
	input wire stop_req,
	input wire wav_pkg::hdr_step_e hdr_step,
	input wire [1:0] channels,
	input wire [wav_pkg::FSIZE_W-1:0] data_size,
	input wire [wav_pkg::FSIZE_W-1:0] data_offset,
	input wire fifo_full,
	output wav_pkg::fcmd_e cmd,
	output logic [wav_pkg::FSIZE_W-1:0] arg1,
	output logic [wav_pkg::REQ_ID_W-1:0] req_id,
	output logic hdr_clear,
	output logic hdr_byte_valid,
	output logic [7:0] hdr_byte,
	output logic [wav_pkg::FSIZE_W-1:0] file_size,
	output logic list_wr_en,
	output logic [LIST_AW-1:0] list_wr_addr,
	output logic [7:0] list_wr_data,
	output logic fifo_wr,
	output logic [31:0] fifo_data,
	output logic playing
);
	import wav_pkg::*;

	typedef enum logic [2:0] {
		S_LIST, // Fetching names
		S_IDLE,
		S_SIZE, // Waiting for file size
		S_HEADER, // Waiting for a header byte
		S_HDR_BYTE, // Byte at the parser
		S_HDR_STEP, // Parser verdict ready
		S_STREAM,
		S_CLOSE
	} seq_state_e;

	seq_state_e state;
	logic [HOST_ID_W-1:0] id_prev; // Id of the last response taken
	logic rsp; // New response in op_q and data_q
	host_op_e op_q;
	logic [31:0] data_q;
	logic [7:0] char_q; // Last low byte, feeds RAM and parser
	logic [15:0] nb_files;
	logic [LIST_AW-1:0] list_cnt; // Next free RAM address
	logic stereo;
	logic [FSIZE_W-1:0] step; // Bytes per audio request
	logic [FSIZE_W-1:0] count; // Audio bytes already pushed
	logic [FSIZE_W-1:0] count_next;
	logic hold; // Word waiting for FIFO room
	logic play_pend;
	logic stop_pend;

	assign step = stereo ? FSIZE_W'(4) : FSIZE_W'(2);
	assign count_next = count + step;
	assign hdr_byte = char_q;
	assign list_wr_data = char_q;

	// Response capture, acted on the next cycle
	always_ff @(posedge clockFiler or negedge rst_n) begin
		if (!rst_n) begin
			id_prev <= '0;
			rsp <= 1'b0;
		end else begin
			rsp <= (host_id != id_prev);
			id_prev <= host_id;
		end
	end

	always_ff @(posedge clockFiler) begin
		op_q <= host_op;
		data_q <= host_data;
		if (rsp) begin
			char_q <= data_q[7:0];
			list_wr_addr <= list_cnt;
		end
		if (rsp && op_q == FILE_SIZE) file_size <= data_q[FSIZE_W-1:0];
		if (rsp && op_q == DATA4) fifo_data <= data_q;
		else if (rsp && op_q == DATA2) fifo_data <= {16'd0, data_q[15:0]}; // Mono zero-extended
	end

	always_ff @(posedge clockFiler or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_LIST;
			cmd <= NONE;
			arg1 <= '0;
			req_id <= '0;
			hdr_clear <= 1'b0;
			hdr_byte_valid <= 1'b0;
			list_wr_en <= 1'b0;
			fifo_wr <= 1'b0;
			playing <= 1'b0;
			nb_files <= '0;
			list_cnt <= '0;
			stereo <= 1'b0;
			count <= '0;
			hold <= 1'b0;
			play_pend <= 1'b0;
			stop_pend <= 1'b0;
		end else begin
			hdr_clear <= 1'b0; // Strobes
			hdr_byte_valid <= 1'b0;
			list_wr_en <= 1'b0;
			fifo_wr <= 1'b0;
			if (play_req) play_pend <= 1'b1;
			if (stop_req && playing) stop_pend <= 1'b1;
			case (state)
				S_LIST: if (rsp) begin
					case (op_q)
						CARD_READY: begin
							cmd <= GET_NB_FILES;
							arg1 <= '0;
							req_id <= req_id + 1'b1;
						end
						NB_FILES: begin
							nb_files <= data_q[15:0];
							arg1 <= '0; // Start at file 0
							list_cnt <= '0;
							cmd <= (data_q[15:0] != 16'd0) ? GET_NAME : PENDING;
							if (data_q[15:0] == 16'd0) state <= S_IDLE;
							req_id <= req_id + 1'b1;
						end
						NAME_CHAR: begin
							list_wr_en <= 1'b1;
							list_cnt <= list_cnt + 1'b1;
							cmd <= GET_NAME; // Same file, next char
							req_id <= req_id + 1'b1;
						end
						NAME_DONE: begin
							if (arg1 + 1'b1 < FSIZE_W'(nb_files)) begin
								cmd <= GET_NAME;
								arg1 <= arg1 + 1'b1;
							end else begin
								cmd <= PENDING; // Listing complete
								state <= S_IDLE;
							end
							req_id <= req_id + 1'b1;
						end
						default: ;
					endcase
				end
				S_IDLE: if (play_pend) begin
					play_pend <= 1'b0;
					stop_pend <= 1'b0;
					playing <= 1'b1;
					cmd <= GET_SIZE;
					arg1 <= FSIZE_W'(sel);
					req_id <= req_id + 1'b1;
					state <= S_SIZE;
				end
				S_SIZE: if (rsp && op_q == FILE_SIZE) begin
					hdr_clear <= 1'b1; // Parser restarts
					cmd <= READ1;
					arg1 <= '0;
					req_id <= req_id + 1'b1;
					state <= S_HEADER;
				end
				S_HEADER: if (rsp && op_q == DATA1) begin
					hdr_byte_valid <= 1'b1;
					state <= S_HDR_BYTE;
				end
				S_HDR_BYTE: state <= S_HDR_STEP; // Parser registers its verdict
				S_HDR_STEP: begin
					req_id <= req_id + 1'b1; // Every verdict issues one request
					case (hdr_step)
						HDR_FOUND: begin
							stereo <= (channels == 2'd2);
							cmd <= (channels == 2'd2) ? READ4 : READ2;
							arg1 <= data_offset; // First audio byte
							count <= '0;
							state <= S_STREAM;
						end
						HDR_FAIL: begin
							cmd <= CLOSE;
							playing <= 1'b0;
							state <= S_CLOSE;
						end
						default: begin
							if (stop_pend) begin
								cmd <= CLOSE;
								playing <= 1'b0;
								state <= S_CLOSE;
							end else begin
								cmd <= READ1;
								arg1 <= arg1 + 1'b1;
								state <= S_HEADER;
							end
						end
					endcase
				end
				S_STREAM: begin
					if (rsp && (op_q == DATA2 || op_q == DATA4)) hold <= 1'b1;
					// Retry each cycle until the FIFO has room, or drop on stop
					if (hold && (!fifo_full || stop_pend)) begin
						hold <= 1'b0;
						fifo_wr <= ~fifo_full;
						req_id <= req_id + 1'b1;
						if (stop_pend || count_next >= data_size) begin
							cmd <= CLOSE;
							playing <= 1'b0;
							state <= S_CLOSE;
						end else begin
							arg1 <= arg1 + step;
							count <= count_next;
						end
					end
				end
				S_CLOSE: if (rsp && op_q == PLAY_END) begin
					cmd <= PENDING;
					req_id <= req_id + 1'b1;
					stop_pend <= 1'b0;
					state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/file_list_ram.sv
`default_nettype none

module file_list_ram #(
	parameter int LIST_AW = 13
) (
	input wire clockFiler,
	input wire wr_en,
	input wire [LIST_AW-1:0] wr_addr,
	input wire [7:0] wr_data,
	input wire [LIST_AW-1:0] rd_addr,
	output logic [7:0] rd_data
);

	logic [7:0] mem [2**LIST_AW]; // One name character per word

	// Registered read, old data on a same-address write
	always_ff @(posedge clockFiler) begin
		if (wr_en) mem[wr_addr] <= wr_data;
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

//--- hdl/gamepad_decoder.sv
`default_nettype none

module gamepad_decoder (
	input wire clockFiler,
	input wire rst_n,
	input wire evt_valid,
	input wire [wav_pkg::EVT_W-1:0] evt_data,
	input wire busy,
	output logic [wav_pkg::SEL_W-1:0] sel,
	output logic play_req,
	output logic stop_req
);
	import wav_pkg::*;

	logic [1:0] evt_type;
	logic [8:0] evt_code;
	logic [8:0] axis; // Last axis value reported
	logic [8:0] axis_prev;
	logic play_lvl; // Button held
	logic stop_lvl;
	logic play_prev;
	logic stop_prev;

	assign evt_type = evt_data[EVT_W-1:EVT_W-2];
	assign evt_code = evt_data[8:0];

	// Levels follow the event one cycle later
	always_ff @(posedge clockFiler or negedge rst_n) begin
		if (!rst_n) begin
			axis <= '0; // Centered
			play_lvl <= 1'b0;
			stop_lvl <= 1'b0;
		end else if (evt_valid) begin
			case (evt_type)
				EVT_AXIS: axis <= evt_code;
				EVT_PRESS, EVT_RELEASE: begin
					if (evt_code == BTN_PLAY) play_lvl <= (evt_type == EVT_PRESS);
					if (evt_code == BTN_STOP) stop_lvl <= (evt_type == EVT_PRESS);
				end
				default: ; // Other event classes ignored
			endcase
		end
	end

	// Edge detection, pulses and selection step on the same cycle
	always_ff @(posedge clockFiler or negedge rst_n) begin
		if (!rst_n) begin
			axis_prev <= '0;
			play_prev <= 1'b0;
			stop_prev <= 1'b0;
			play_req <= 1'b0;
			stop_req <= 1'b0;
			sel <= '0;
		end else begin
			play_prev <= play_lvl;
			stop_prev <= stop_lvl;
			play_req <= play_lvl & ~play_prev & ~busy; // Ignored while streaming
			stop_req <= stop_lvl & ~stop_prev;
			axis_prev <= axis;
			if (axis != axis_prev) begin
				if (axis == AXIS_UP) sel <= sel - 1'b1; // Wraps to 15
				else if (axis == AXIS_DOWN) sel <= sel + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/sample_fifo.sv
`default_nettype none

module sample_fifo #(
	parameter int FIFO_DEPTH = 16
) (
	input wire clockFiler,
	input wire rst_n,
	input wire wr,
	input wire [31:0] wr_data,
	input wire rd,
	output logic [31:0] rd_data,
	output logic full,
	output logic empty
);

	localparam int AW = $clog2(FIFO_DEPTH);
	localparam int CW = $clog2(FIFO_DEPTH + 1); // Holds 0 to FIFO_DEPTH

	logic [31:0] mem [FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic do_wr;
	logic do_rd;

	assign full = (count == CW'(FIFO_DEPTH));
	assign empty = (count == '0);
	assign do_wr = wr & ~full; // Write on full is dropped
	assign do_rd = rd & ~empty;
	assign rd_data = mem[rd_ptr]; // Head shown ahead of the pop

	always_ff @(posedge clockFiler) begin
		if (do_wr) mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge clockFiler or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd) rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ; // Both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/wav_header_parser.sv
`default_nettype none

module wav_header_parser (
	input wire clockFiler,
	input wire rst_n,
	input wire hdr_clear,
	input wire hdr_byte_valid,
	input wire [7:0] hdr_byte,
	input wire [wav_pkg::FSIZE_W-1:0] file_size,
	output wav_pkg::hdr_step_e hdr_step,
	output logic [1:0] channels,
	output logic [wav_pkg::FSIZE_W-1:0] data_size,
	output logic [wav_pkg::FSIZE_W-1:0] data_offset
);
	import wav_pkg::*;

	typedef enum logic [1:0] {
		P_SEEK_FMT,
		P_FMT, // Inside the fmt body
		P_SEEK_DATA,
		P_SIZE // Data size bytes
	} phase_e;

	phase_e phase;
	logic [31:0] window; // Last four bytes, oldest in the low byte
	logic [31:0] win_next;
	logic [FSIZE_W-1:0] pos; // Position of the incoming byte
	logic [2:0] cnt; // Bytes since the last tag
	logic last_byte;
	logic fmt_done;
	logic size_done;

	assign win_next = {hdr_byte, window[31:8]};
	assign last_byte = (pos + 1'b1 >= file_size);
	assign fmt_done = hdr_byte_valid && phase == P_FMT && cnt == 3'd7; // 8th byte after tag
	assign size_done = hdr_byte_valid && phase == P_SIZE && cnt == 3'd3;

	always_ff @(posedge clockFiler or negedge rst_n) begin
		if (!rst_n) begin
			phase <= P_SEEK_FMT;
			window <= '0;
			pos <= '0;
			cnt <= '0;
			hdr_step <= HDR_CONT;
		end else if (hdr_clear) begin
			phase <= P_SEEK_FMT; // New file
			window <= '0;
			pos <= '0;
			cnt <= '0;
			hdr_step <= HDR_CONT;
		end else if (hdr_byte_valid) begin
			window <= win_next;
			pos <= pos + 1'b1;
			cnt <= cnt + 1'b1;
			hdr_step <= last_byte ? HDR_FAIL : HDR_CONT; // One verdict per byte
			case (phase)
				P_SEEK_FMT: if (win_next == TAG_FMT) begin
					phase <= P_FMT;
					cnt <= '0;
				end
				P_FMT: if (fmt_done) begin
					phase <= P_SEEK_DATA;
					cnt <= '0;
				end
				P_SEEK_DATA: if (win_next == TAG_DATA) begin
					phase <= P_SIZE;
					cnt <= '0;
				end
				default: if (size_done) hdr_step <= HDR_FOUND;
			endcase
		end
	end

	// Header fields
	always_ff @(posedge clockFiler) begin
		if (fmt_done) channels <= win_next[17:16]; // Low bits of the 7th byte
		if (size_done) begin
			data_size <= win_next[FSIZE_W-1:0];
			data_offset <= pos + 1'b1; // Audio right after the size
		end
	end

endmodule

`default_nettype wire

//--- hdl/wav_pkg.sv
`default_nettype none

package wav_pkg;

	// Field widths
	localparam int FSIZE_W = 26; // File positions and sizes
	localparam int REQ_ID_W = 4;
	localparam int HOST_ID_W = 16;
	localparam int SEL_W = 4; // Selection index, wraps at 16
	localparam int EVT_W = 11; // 2-bit type over 9-bit code

	// Gamepad event types and codes
	localparam logic [1:0] EVT_AXIS = 2'd0;
	localparam logic [1:0] EVT_PRESS = 2'd2;
	localparam logic [1:0] EVT_RELEASE = 2'd1;
	localparam logic [8:0] AXIS_UP = 9'd511; // Axis at -1
	localparam logic [8:0] AXIS_DOWN = 9'd1;
	localparam logic [8:0] BTN_STOP = 9'd306;
	localparam logic [8:0] BTN_PLAY = 9'd305;

	// Chunk tags as seen in a little-endian shift window
	localparam logic [31:0] TAG_FMT = 32'h20746D66; // "fmt "
	localparam logic [31:0] TAG_DATA = 32'h61746164; // "data"

	// Card host response opcodes
	typedef enum logic [15:0] {
		CARD_READY = 16'd1,
		NB_FILES = 16'd2,
		NAME_CHAR = 16'd3,
		NAME_DONE = 16'd4,
		DATA2 = 16'd5, // Two file bytes
		PLAY_END = 16'd6,
		IDLE = 16'd7,
		FILE_SIZE = 16'd8,
		DATA1 = 16'd9, // One file byte
		DATA4 = 16'd10 // Four file bytes
	} host_op_e;

	// Player request commands
	typedef enum logic [7:0] {
		NONE = 8'd0,
		GET_NB_FILES = 8'd1,
		GET_NAME = 8'd2, // arg1 is the file number
		READ2 = 8'd3,
		CLOSE = 8'd4,
		PENDING = 8'd5,
		GET_SIZE = 8'd6, // Also opens the file
		READ1 = 8'd31,
		READ4 = 8'd34
	} fcmd_e;

	// Header parser verdict per byte
	typedef enum logic [1:0] {
		HDR_CONT = 2'd0,
		HDR_FOUND = 2'd1,
		HDR_FAIL = 2'd2
	} hdr_step_e;

endpackage

`default_nettype wire

//--- hdl/wav_player.sv
`default_nettype none

module wav_player #(
	parameter int FIFO_DEPTH = 16,
	parameter int LIST_AW = 13
) (
	input wire clockFiler,
	input wire rst_n,
	input wire wav_pkg::host_op_e host_op,
	input wire [wav_pkg::HOST_ID_W-1:0] host_id,
	input wire [31:0] host_data,
	input wire evt_valid,
	input wire [wav_pkg::EVT_W-1:0] evt_data,
	input wire sample_rd,
	input wire [LIST_AW-1:0] list_raddr,
	output wav_pkg::fcmd_e cmd,
	output logic [wav_pkg::FSIZE_W-1:0] arg1,
	output logic [wav_pkg::REQ_ID_W-1:0] req_id,
	output logic [31:0] sample,
	output logic sample_empty,
	output logic [7:0] list_rdata,
	output logic playing,
	output logic [wav_pkg::SEL_W-1:0] sel
);
	import wav_pkg::*;

	logic play_req; // Gamepad pulses
	logic stop_req;

	// Sequencer to parser
	logic hdr_clear;
	logic hdr_byte_valid;
	logic [7:0] hdr_byte;
	logic [FSIZE_W-1:0] file_size;
	hdr_step_e hdr_step;
	logic [1:0] channels;
	logic [FSIZE_W-1:0] data_size;
	logic [FSIZE_W-1:0] data_offset;

	logic list_wr_en; // Name characters
	logic [LIST_AW-1:0] list_wr_addr;
	logic [7:0] list_wr_data;

	logic fifo_wr; // Audio words
	logic [31:0] fifo_data;
	logic fifo_full;

	gamepad_decoder u_pad (
		.clockFiler(clockFiler), .rst_n(rst_n),
		.evt_valid(evt_valid), .evt_data(evt_data),
		.busy(playing), // No new play while streaming
		.sel(sel), .play_req(play_req), .stop_req(stop_req)
	);

	card_sequencer #(.LIST_AW(LIST_AW)) u_seq (
		.clockFiler(clockFiler), .rst_n(rst_n),
		.host_op(host_op), .host_id(host_id), .host_data(host_data),
		.sel(sel), .play_req(play_req), .stop_req(stop_req),
		.hdr_step(hdr_step), .channels(channels),
		.data_size(data_size), .data_offset(data_offset),
		.fifo_full(fifo_full),
		.cmd(cmd), .arg1(arg1), .req_id(req_id),
		.hdr_clear(hdr_clear), .hdr_byte_valid(hdr_byte_valid), .hdr_byte(hdr_byte),
		.file_size(file_size),
		.list_wr_en(list_wr_en), .list_wr_addr(list_wr_addr), .list_wr_data(list_wr_data),
		.fifo_wr(fifo_wr), .fifo_data(fifo_data),
		.playing(playing)
	);

	wav_header_parser u_parser (
		.clockFiler(clockFiler), .rst_n(rst_n),
		.hdr_clear(hdr_clear), .hdr_byte_valid(hdr_byte_valid), .hdr_byte(hdr_byte),
		.file_size(file_size),
		.hdr_step(hdr_step), .channels(channels),
		.data_size(data_size), .data_offset(data_offset)
	);

	file_list_ram #(.LIST_AW(LIST_AW)) u_list (
		.clockFiler(clockFiler),
		.wr_en(list_wr_en), .wr_addr(list_wr_addr), .wr_data(list_wr_data),
		.rd_addr(list_raddr), .rd_data(list_rdata)
	);

	sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
		.clockFiler(clockFiler), .rst_n(rst_n),
		.wr(fifo_wr), .wr_data(fifo_data),
		.rd(sample_rd), .rd_data(sample),
		.full(fifo_full), .empty(sample_empty)
	);

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build the WAV player testbench with Verilator, run it, then look for the pass line
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing -Wno-fatal -f files.f --top-module wav_player_tb \
	-o wav_sim > build.log 2>&1 &&
( ./obj_dir/wav_sim > sim.log 2>&1 || true ) &&
grep -q "TEST RESULT: PASS" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed, see build.log and sim.log"; exit 1; }

//--- verification/card_host_model.sv
`default_nettype none

module card_host_model (
	input wire clockFiler,
	input wire rst_n,
	input wire wav_pkg::fcmd_e cmd,
	input wire [wav_pkg::FSIZE_W-1:0] arg1,
	input wire [wav_pkg::REQ_ID_W-1:0] req_id,
	output wav_pkg::host_op_e host_op,
	output logic [wav_pkg::HOST_ID_W-1:0] host_id,
	output logic [31:0] host_data
);
	timeunit 1ns;
	timeprecision 1ps;
	import wav_pkg::*;

	logic [7:0] tdata [0:511]; // Same image as the testbench
	logic [31:0] rng_state;
	logic [REQ_ID_W-1:0] last_req;
	int name_pos; // Next character of the current name
	int open_file;

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state;
	endfunction

	function automatic logic [7:0] file_byte(input int f, input int a);
		int base;
		base = (f == 0) ? 'h40 : 'h100;
		return tdata[base + a];
	endfunction

	// New response: payload first, then the id bump
	task automatic answer(input host_op_e op, input logic [31:0] d);
		host_op = op;
		host_data = d;
		host_id = host_id + 1'b1;
	endtask

	task automatic serve_request();
		int delay;
		int a;
		int name_base;
		logic [31:0] r;
		logic [31:0] d;
		host_op_e op;
		logic send;
		r = lcg_next();
		delay = 1 + int'(r[17:16]); // 1 to 4 cycles
		a = int'(arg1);
		send = 1'b1;
		d = '0;
		op = IDLE;
		case (cmd)
			GET_NB_FILES: begin
				op = NB_FILES;
				d = 32'(tdata[0]);
			end
			GET_NAME: begin
				name_base = 'h10 + ((a == 0) ? 0 : int'(tdata[1]));
				if (name_pos < int'(tdata[1 + a])) begin
					op = NAME_CHAR;
					d = 32'(tdata[name_base + name_pos]);
					name_pos++;
				end else begin
					op = NAME_DONE; // Next file starts from its first char
					name_pos = 0;
				end
			end
			GET_SIZE: begin
				open_file = a;
				op = FILE_SIZE;
				d = 32'(tdata[3 + a]);
			end
			READ1: begin
				op = DATA1;
				d = 32'(file_byte(open_file, a));
			end
			READ2: begin
				op = DATA2;
				d = {16'd0, file_byte(open_file, a + 1), file_byte(open_file, a)};
			end
			READ4: begin
				op = DATA4;
				d = {file_byte(open_file, a + 3), file_byte(open_file, a + 2),
					file_byte(open_file, a + 1), file_byte(open_file, a)};
			end
			CLOSE: op = PLAY_END;
			default: send = 1'b0; // PENDING and NONE get no answer
		endcase
		if (send) begin
			repeat (delay) @(posedge clockFiler);
			#2;
			answer(op, d);
		end
	endtask

	initial begin
		$readmemh("verification/wav_testdata.txt", tdata);
		rng_state = 32'h538c;
		host_op = IDLE;
		host_id = '0;
		host_data = '0;
		last_req = '0;
		name_pos = 0;
		open_file = 0;
		@(posedge rst_n);
		repeat (3) @(posedge clockFiler);
		#2;
		answer(CARD_READY, 32'd0); // Card is up
		forever begin
			@(posedge clockFiler);
			#2;
			if (req_id != last_req) begin
				last_req = req_id;
				serve_request();
			end
		end
	end

endmodule

`default_nettype wire

//--- verification/wav_player_tb.sv
`default_nettype none

module wav_player_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import wav_pkg::*;

	localparam int LIST_AW = 13;
	localparam int FIFO_DEPTH = 16;
	localparam int NAMES = 'h10; // Name characters in the image
	localparam int SCRIPT = 'h20; // Axis script

	logic clockFiler;
	logic rst_n;
	host_op_e host_op;
	logic [HOST_ID_W-1:0] host_id;
	logic [31:0] host_data;
	logic evt_valid;
	logic [EVT_W-1:0] evt_data;
	logic sample_rd;
	logic [LIST_AW-1:0] list_raddr;
	fcmd_e cmd;
	logic [FSIZE_W-1:0] arg1;
	logic [REQ_ID_W-1:0] req_id;
	logic [31:0] sample;
	logic sample_empty;
	logic [7:0] list_rdata;
	logic playing;
	logic [SEL_W-1:0] sel;

	logic [7:0] tdata [0:511];
	logic [31:0] rng_state;
	logic [SEL_W-1:0] sel_model; // Selection kept apart from the DUT
	int cycles = 0;
	int cycle_limit = 0;

	wav_player #(.FIFO_DEPTH(FIFO_DEPTH), .LIST_AW(LIST_AW)) uut (
		.clockFiler(clockFiler), .rst_n(rst_n),
		.host_op(host_op), .host_id(host_id), .host_data(host_data),
		.evt_valid(evt_valid), .evt_data(evt_data),
		.sample_rd(sample_rd), .list_raddr(list_raddr),
		.cmd(cmd), .arg1(arg1), .req_id(req_id),
		.sample(sample), .sample_empty(sample_empty), .list_rdata(list_rdata),
		.playing(playing), .sel(sel)
	);

	card_host_model host (
		.clockFiler(clockFiler), .rst_n(rst_n),
		.cmd(cmd), .arg1(arg1), .req_id(req_id),
		.host_op(host_op), .host_id(host_id), .host_data(host_data)
	);

	initial begin
		clockFiler = 1'b0;
		forever #20 clockFiler = ~clockFiler; // 40 ns period
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_char(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp)
			report_failure($sformatf("MISMATCH %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_sample(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (act !== exp)
			report_failure($sformatf("MISMATCH %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_cmd(input string name, input fcmd_e exp, input fcmd_e act);
		if (act !== exp)
			report_failure($sformatf("MISMATCH %s: expected %s, actual %s",
				name, exp.name(), act.name()));
	endtask

	task automatic check_sel(input string name, input logic [SEL_W-1:0] exp,
		input logic [SEL_W-1:0] act);
		if (act !== exp)
			report_failure($sformatf("MISMATCH %s: expected %0d, actual %0d", name, exp, act));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
			report_failure($sformatf("MISMATCH %s: expected %b, actual %b", name, exp, act));
	endtask

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state;
	endfunction

	// Little-endian audio word k from the data offset
	function automatic logic [31:0] expected_sample(input int f, input int k);
		int step;
		int a;
		step = (tdata[5 + f] == 8'd2) ? 4 : 2;
		a = ((f == 0) ? 'h40 : 'h100) + int'(tdata[7 + f]) + k * step;
		if (step == 4)
			return {tdata[a + 3], tdata[a + 2], tdata[a + 1], tdata[a]};
		return {16'd0, tdata[a + 1], tdata[a]}; // Mono zero-extended
	endfunction

	task automatic next_cycle();
		@(posedge clockFiler);
		#2; // Inputs change just after the edge
	endtask

	task automatic send_event(input logic [1:0] kind, input logic [8:0] code);
		evt_valid = 1'b1;
		evt_data = {kind, code};
		next_cycle();
		evt_valid = 1'b0;
	endtask

	task automatic step_axis(input logic [8:0] code);
		send_event(EVT_AXIS, code);
		send_event(EVT_AXIS, 9'd0); // Back to center
		if (code == AXIS_UP) sel_model = sel_model - 1'b1;
		else sel_model = sel_model + 1'b1;
		next_cycle();
		next_cycle();
		check_sel("axis step", sel_model, sel);
	endtask

	// Play the selected file and pop samples at a random pace
	task automatic stream_file(input int f, input bit hold_first, input int stop_after);
		int step;
		int n;
		int got;
		int quiet;
		int stop_phase;
		bit was_playing;
		logic [31:0] r;
		fcmd_e exp_cmd;
		step = (tdata[5 + f] == 8'd2) ? 4 : 2;
		n = int'(tdata[9 + f]) / step;
		exp_cmd = (step == 4) ? READ4 : READ2;
		got = 0;
		quiet = 0;
		stop_phase = 0;
		send_event(EVT_PRESS, BTN_PLAY);
		send_event(EVT_RELEASE, BTN_PLAY);
		while (!playing) next_cycle();
		while (cmd == GET_SIZE || cmd == READ1) next_cycle(); // Header phase
		check_cmd($sformatf("file %0d first audio request", f), exp_cmd, cmd);
		if (hold_first) begin
			// At most 8 cycles per word, so the FIFO fills and one more word waits
			repeat (8 * (FIFO_DEPTH + 1)) next_cycle();
		end
		was_playing = 1'b1;
		while (quiet < 3) begin
			sample_rd = 1'b0;
			evt_valid = 1'b0;
			if (was_playing && !playing) check_cmd($sformatf("file %0d close", f), CLOSE, cmd);
			was_playing = playing;
			if (stop_phase == 1) begin
				evt_valid = 1'b1;
				evt_data = {EVT_RELEASE, BTN_STOP};
				stop_phase = 2;
			end else if (stop_after > 0 && got == stop_after && stop_phase == 0) begin
				evt_valid = 1'b1;
				evt_data = {EVT_PRESS, BTN_STOP};
				stop_phase = 1;
			end
			r = lcg_next();
			if (!sample_empty && r[17:16] != 2'd0) begin
				if (got >= n) report_failure($sformatf("file %0d: sample past the data end", f));
				check_sample($sformatf("file %0d sample %0d", f, got), expected_sample(f, got),
					sample);
				sample_rd = 1'b1; // Pop at the next edge
				got++;
			end
			quiet = (playing || !sample_empty) ? 0 : quiet + 1;
			next_cycle();
		end
		sample_rd = 1'b0;
		evt_valid = 1'b0;
		if (stop_after == 0 && got != n)
			report_failure($sformatf("file %0d gave %0d samples, %0d expected", f, got, n));
		if (stop_after > 0 && got < stop_after)
			report_failure($sformatf("file %0d stopped before %0d samples", f, stop_after));
		if (stop_after > 0 && got >= n)
			report_failure($sformatf("file %0d: stop did not end the playback early", f));
	endtask

	// Watchdog
	initial begin
		wait (cycle_limit > 0);
		while (cycles < cycle_limit) begin
			@(posedge clockFiler);
			cycles++;
		end
		report_failure($sformatf("timeout after %0d clock cycles", cycle_limit));
	end

	initial begin
		int addr;
		int name_total;
		int total;
		rst_n = 1'b0;
		evt_valid = 1'b0;
		evt_data = '0;
		sample_rd = 1'b0;
		list_raddr = '0;
		rng_state = 32'h538c;
		sel_model = '0;
		$readmemh("verification/wav_testdata.txt", tdata);
		name_total = int'(tdata[1]) + int'(tdata[2]);
		total = 11 + name_total + int'(tdata[3]) + int'(tdata[4]) + 1 + int'(tdata[SCRIPT]);
		cycle_limit = 40 * total + 2000;
		repeat (10) @(posedge clockFiler);
		#2;
		check_cmd("cmd in reset", NONE, cmd);
		check_flag("sample_empty in reset", 1'b1, sample_empty);
		check_flag("playing in reset", 1'b0, playing);
		rst_n = 1'b1;

		while (cmd != PENDING) next_cycle(); // Listing done
		for (addr = 0; addr < name_total; addr++) begin
			list_raddr = LIST_AW'(addr);
			next_cycle();
			check_char($sformatf("file list char %0d", addr), tdata[NAMES + addr], list_rdata);
		end

		for (addr = 1; addr <= int'(tdata[SCRIPT]); addr++)
			step_axis((tdata[SCRIPT + addr] == 8'hFF) ? AXIS_UP : AXIS_DOWN);

		stream_file(0, 1'b1, 0); // Mono under back-pressure
		step_axis(AXIS_DOWN);
		stream_file(1, 1'b0, 0); // Stereo to the end
		stream_file(1, 1'b0, 5); // Stereo stopped early

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/wav_testdata.txt
// Byte image read with $readmemh, one hex byte per entry
// @000 nfiles, name len 0/1, wav len 0/1, channels 0/1, data offset 0/1, data size 0/1
@000
02 08 08 68 7C 01 02 38 2C 30 50
// @010 file names back to back, TONE.WAV then BEEP.WAV
@010
54 4F 4E 45 2E 57 41 56 42 45 45 50 2E 57 41 56
// @020 axis script, step count then FF for up and 01 for down
@020
06 FF FF 01 01 01 FF
// @040 file 0, mono with a JUNK chunk ahead of fmt
@040
52 49 46 46 60 00 00 00 57 41 56 45 4A 55 4E 4B
04 00 00 00 AA BB CC DD 66 6D 74 20 10 00 00 00
01 00 01 00 40 1F 00 00 80 3E 00 00 02 00 10 00
64 61 74 61 30 00 00 00 10 80 11 81 12 82 13 83
14 84 15 85 16 86 17 87 18 88 19 89 1A 8A 1B 8B
1C 8C 1D 8D 1E 8E 1F 8F 20 90 21 91 22 92 23 93
24 94 25 95 26 96 27 97
// @100 file 1, stereo
@100
52 49 46 46 74 00 00 00 57 41 56 45 66 6D 74 20
10 00 00 00 01 00 02 00 40 1F 00 00 00 7D 00 00
04 00 10 00 64 61 74 61 50 00 00 00 30 31 32 33
34 35 36 37 38 39 3A 3B 3C 3D 3E 3F 40 41 42 43
44 45 46 47 48 49 4A 4B 4C 4D 4E 4F 50 51 52 53
54 55 56 57 58 59 5A 5B 5C 5D 5E 5F 60 61 62 63
64 65 66 67 68 69 6A 6B 6C 6D 6E 6F 70 71 72 73
74 75 76 77 78 79 7A 7B 7C 7D 7E 7F
